/* files.f */
src/pip_isa_pkg.sv
src/pip_ctrl_pkg.sv
src/ifetch.sv
src/idec.sv
src/ex.sv
src/mem.sv
src/pipeline.sv
test/pipeline_assertions.sv
test/pipeline_tb.sv

/* src/ex.sv */
module ex (
  input  logic                                clock_i,
  input  logic                                reset_i,
  input  logic                                stall_i,
  input  logic [pip_ctrl_pkg::DATA_W-1:0]     ex_a_i,
  input  logic [pip_ctrl_pkg::DATA_W-1:0]     ex_b_i,
  input  logic [pip_isa_pkg::REG_ADDR_W-1:0]  ex_rs_i,
  input  logic [pip_isa_pkg::REG_ADDR_W-1:0]  ex_rt_i,
  input  pip_ctrl_pkg::alu_op_t               ex_alu_op_i,
  input  logic                                ex_use_imm_i,
  input  logic [pip_ctrl_pkg::DATA_W-1:0]     ex_imm_i,
  input  logic [pip_isa_pkg::REG_ADDR_W-1:0]  ex_shamt_i,
  input  logic [pip_isa_pkg::REG_ADDR_W-1:0]  ex_dest_i,
  input  logic                                ex_dest_valid_i,
  input  pip_ctrl_pkg::ls_op_t                ls_op_i,
  output logic [pip_ctrl_pkg::DATA_W-1:0]     mem_result_o,
  output logic [pip_ctrl_pkg::DATA_W-1:0]     mem_store_data_o,
  output pip_ctrl_pkg::ls_op_t                mem_ls_op_o,
  output logic [pip_isa_pkg::REG_ADDR_W-1:0]  mem_dest_o,
  output logic                                mem_dest_valid_o,
  input  logic [pip_ctrl_pkg::DATA_W-1:0]     wb_result_i,
  input  logic [pip_isa_pkg::REG_ADDR_W-1:0]  wb_dest_i,
  input  logic                                wb_dest_valid_i
);

  logic [pip_ctrl_pkg::DATA_W-1:0] a_fwd;
  logic [pip_ctrl_pkg::DATA_W-1:0] b_fwd;
  logic [pip_ctrl_pkg::DATA_W-1:0] op_b;
  logic [pip_ctrl_pkg::DATA_W-1:0] alu_res;
  logic [pip_ctrl_pkg::DATA_W-1:0] a_hold_q;
  logic [pip_ctrl_pkg::DATA_W-1:0] b_hold_q;
  logic                            hold_q;

  // EX/MEM first, then MEM/WB, then the operand kept over a stall
  function automatic logic [pip_ctrl_pkg::DATA_W-1:0] forward(
    input logic [pip_isa_pkg::REG_ADDR_W-1:0] src,
    input logic [pip_ctrl_pkg::DATA_W-1:0]    held,
    input logic [pip_ctrl_pkg::DATA_W-1:0]    decoded
  );
    if (mem_dest_valid_o && mem_dest_o == src) begin
      return mem_result_o;
    end else if (wb_dest_valid_i && wb_dest_i == src) begin
      return wb_result_i;
    end else if (hold_q) begin
      return held;
    end
    return decoded;
  endfunction

  always_comb begin
    a_fwd = forward(ex_rs_i, a_hold_q, ex_a_i);
    b_fwd = forward(ex_rt_i, b_hold_q, ex_b_i);
  end

  assign op_b  = ex_use_imm_i ? ex_imm_i : b_fwd;

  always_comb begin
    case (ex_alu_op_i)
      pip_ctrl_pkg::ALU_ADD:  alu_res = a_fwd + op_b;
      pip_ctrl_pkg::ALU_SUB:  alu_res = a_fwd - op_b;
      pip_ctrl_pkg::ALU_AND:  alu_res = a_fwd & op_b;
      pip_ctrl_pkg::ALU_OR:   alu_res = a_fwd | op_b;
      pip_ctrl_pkg::ALU_XOR:  alu_res = a_fwd ^ op_b;
      pip_ctrl_pkg::ALU_SLT:  alu_res = {31'b0, $signed(a_fwd) < $signed(op_b)};
      pip_ctrl_pkg::ALU_SLTU: alu_res = {31'b0, a_fwd < op_b};
      pip_ctrl_pkg::ALU_SLL:  alu_res = op_b << ex_shamt_i;
      pip_ctrl_pkg::ALU_SRL:  alu_res = op_b >> ex_shamt_i;
      pip_ctrl_pkg::ALU_LUI:  alu_res = {op_b[15:0], 16'b0};
      default:                alu_res = '0;
    endcase
  end

  // MEM/WB drains during a stall, so keep the resolved operands
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      hold_q <= 1'b0;
    end else begin
      hold_q <= stall_i;
    end
  end

  always_ff @(posedge clock_i) begin
    if (stall_i) begin
      a_hold_q <= a_fwd;
      b_hold_q <= b_fwd;
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      mem_ls_op_o      <= pip_ctrl_pkg::LS_NONE;
      mem_dest_valid_o <= 1'b0;
    end else if (!stall_i) begin
      mem_ls_op_o      <= ls_op_i;
      mem_dest_valid_o <= ex_dest_valid_i;
    end
  end

  always_ff @(posedge clock_i) begin
    if (!stall_i) begin
      mem_result_o     <= alu_res;
      mem_store_data_o <= b_fwd;
      mem_dest_o       <= ex_dest_i;
    end
  end

endmodule

/* src/idec.sv */
module idec (
  input  logic                                clock_i,
  input  logic                                reset_i,
  input  logic                                stall_i,
  input  logic [pip_ctrl_pkg::DATA_W-1:0]     if_inst_i,
  output logic [pip_isa_pkg::REG_ADDR_W-1:0]  rfile_rd_addr1_o,
  output logic [pip_isa_pkg::REG_ADDR_W-1:0]  rfile_rd_addr2_o,
  input  logic [pip_ctrl_pkg::DATA_W-1:0]     rfile_rd_data1_i,
  input  logic [pip_ctrl_pkg::DATA_W-1:0]     rfile_rd_data2_i,
  output logic                                hazard_o,
  output logic [pip_ctrl_pkg::DATA_W-1:0]     ex_a_o,
  output logic [pip_ctrl_pkg::DATA_W-1:0]     ex_b_o,
  output logic [pip_isa_pkg::REG_ADDR_W-1:0]  ex_rs_o,
  output logic [pip_isa_pkg::REG_ADDR_W-1:0]  ex_rt_o,
  output pip_ctrl_pkg::alu_op_t               ex_alu_op_o,
  output logic                                ex_use_imm_o,
  output logic [pip_ctrl_pkg::DATA_W-1:0]     ex_imm_o,
  output logic [pip_isa_pkg::REG_ADDR_W-1:0]  ex_shamt_o,
  output pip_ctrl_pkg::ls_op_t                ex_ls_op_o,
  output logic [pip_isa_pkg::REG_ADDR_W-1:0]  ex_dest_o,
  output logic                                ex_dest_valid_o
);

  pip_isa_pkg::opcode_t                opc;
  pip_isa_pkg::funct_t                 funct;
  logic [pip_isa_pkg::REG_ADDR_W-1:0]  rs;
  logic [pip_isa_pkg::REG_ADDR_W-1:0]  rt;
  logic [pip_isa_pkg::REG_ADDR_W-1:0]  rd;
  logic [pip_isa_pkg::IMM_W-1:0]       imm16;
  pip_ctrl_pkg::alu_op_t               alu_op;
  pip_ctrl_pkg::ls_op_t                ls_op;
  logic [pip_isa_pkg::REG_ADDR_W-1:0]  dest;
  logic [pip_ctrl_pkg::DATA_W-1:0]     imm_ext;
  logic                                use_imm;
  logic                                zero_ext;
  logic                                known;
  logic                                writes;
  logic                                uses_rs;
  logic                                uses_rt;
  logic                                dest_valid;

  assign opc   = pip_isa_pkg::opcode_t'(if_inst_i[pip_isa_pkg::OPC_LSB +: 6]);
  assign funct = pip_isa_pkg::funct_t'(if_inst_i[pip_isa_pkg::FUNCT_LSB +: 6]);
  assign rs    = if_inst_i[pip_isa_pkg::RS_LSB +: pip_isa_pkg::REG_ADDR_W];
  assign rt    = if_inst_i[pip_isa_pkg::RT_LSB +: pip_isa_pkg::REG_ADDR_W];
  assign rd    = if_inst_i[pip_isa_pkg::RD_LSB +: pip_isa_pkg::REG_ADDR_W];
  assign imm16 = if_inst_i[pip_isa_pkg::IMM_W-1:0];

  assign rfile_rd_addr1_o = rs;
  assign rfile_rd_addr2_o = rt;

  always_comb begin
    alu_op   = pip_ctrl_pkg::ALU_ADD;
    ls_op    = pip_ctrl_pkg::LS_NONE;
    dest     = rt;
    use_imm  = 1'b1;
    zero_ext = 1'b0;
    known    = 1'b1;
    writes   = 1'b1;
    uses_rs  = 1'b1;
    uses_rt  = 1'b0;
    case (opc)
      pip_isa_pkg::OPC_SPECIAL: begin
        dest    = rd;
        use_imm = 1'b0;
        uses_rt = 1'b1;
        case (funct)
          pip_isa_pkg::FN_SLL: begin
            alu_op  = pip_ctrl_pkg::ALU_SLL;
            uses_rs = 1'b0;
          end
          pip_isa_pkg::FN_SRL: begin
            alu_op  = pip_ctrl_pkg::ALU_SRL;
            uses_rs = 1'b0;
          end
          pip_isa_pkg::FN_ADDU: alu_op = pip_ctrl_pkg::ALU_ADD;
          pip_isa_pkg::FN_SUBU: alu_op = pip_ctrl_pkg::ALU_SUB;
          pip_isa_pkg::FN_AND:  alu_op = pip_ctrl_pkg::ALU_AND;
          pip_isa_pkg::FN_OR:   alu_op = pip_ctrl_pkg::ALU_OR;
          pip_isa_pkg::FN_XOR:  alu_op = pip_ctrl_pkg::ALU_XOR;
          pip_isa_pkg::FN_SLT:  alu_op = pip_ctrl_pkg::ALU_SLT;
          pip_isa_pkg::FN_SLTU: alu_op = pip_ctrl_pkg::ALU_SLTU;
          default:              known  = 1'b0;
        endcase
      end
      pip_isa_pkg::OPC_ADDIU: alu_op = pip_ctrl_pkg::ALU_ADD;
      pip_isa_pkg::OPC_SLTI:  alu_op = pip_ctrl_pkg::ALU_SLT;
      pip_isa_pkg::OPC_ANDI: begin
        alu_op   = pip_ctrl_pkg::ALU_AND;
        zero_ext = 1'b1;
      end
      pip_isa_pkg::OPC_ORI: begin
        alu_op   = pip_ctrl_pkg::ALU_OR;
        zero_ext = 1'b1;
      end
      pip_isa_pkg::OPC_XORI: begin
        alu_op   = pip_ctrl_pkg::ALU_XOR;
        zero_ext = 1'b1;
      end
      pip_isa_pkg::OPC_LUI: begin
        alu_op   = pip_ctrl_pkg::ALU_LUI;
        zero_ext = 1'b1;
        uses_rs  = 1'b0;
      end
      pip_isa_pkg::OPC_LW: ls_op = pip_ctrl_pkg::LS_LOAD;
      pip_isa_pkg::OPC_SW: begin
        ls_op   = pip_ctrl_pkg::LS_STORE;
        writes  = 1'b0;
        uses_rt = 1'b1;
      end
      default: known = 1'b0;
    endcase
  end

  assign imm_ext    = zero_ext ? {{(pip_ctrl_pkg::DATA_W-pip_isa_pkg::IMM_W){1'b0}}, imm16}
                               : {{(pip_ctrl_pkg::DATA_W-pip_isa_pkg::IMM_W){imm16[15]}}, imm16};
  assign dest_valid = known & writes & (dest != '0);

  // Load in EX whose result is needed here
  assign hazard_o = (ex_ls_op_o == pip_ctrl_pkg::LS_LOAD) & ex_dest_valid_o &
                    ((uses_rs & (rs == ex_dest_o)) | (uses_rt & (rt == ex_dest_o)));

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      ex_dest_valid_o <= 1'b0;
      ex_ls_op_o      <= pip_ctrl_pkg::LS_NONE;
    end else if (!stall_i) begin
      ex_dest_valid_o <= dest_valid & ~hazard_o;
      ex_ls_op_o      <= hazard_o ? pip_ctrl_pkg::LS_NONE : ls_op;
    end
  end

  always_ff @(posedge clock_i) begin
    if (!stall_i) begin
      ex_a_o       <= rfile_rd_data1_i;
      ex_b_o       <= rfile_rd_data2_i;
      ex_rs_o      <= rs;
      ex_rt_o      <= rt;
      ex_alu_op_o  <= alu_op;
      ex_use_imm_o <= use_imm;
      ex_imm_o     <= imm_ext;
      ex_shamt_o   <= if_inst_i[pip_isa_pkg::SHAMT_LSB +: pip_isa_pkg::REG_ADDR_W];
      ex_dest_o    <= dest;
    end
  end

endmodule

/* src/ifetch.sv */
module ifetch (
  input  logic                            clock_i,
  input  logic                            reset_i,
  input  logic                            stall_i,
  output logic [pip_ctrl_pkg::DATA_W-1:0] icache_addr_o,
  output logic                            icache_rd_o,
  input  logic [pip_ctrl_pkg::DATA_W-1:0] icache_data_i,
  input  logic                            icache_waitrequest_i,
  output logic [pip_ctrl_pkg::DATA_W-1:0] if_inst_o
);

  logic [pip_ctrl_pkg::DATA_W-1:0] pc_q;
  logic [pip_ctrl_pkg::DATA_W-1:0] held_word_q;
  logic                            run_q;
  logic                            pending_q;
  logic                            held_valid_q;
  logic                            read_done;

  // A started read stays up until the cache accepts it, even under stall
  assign icache_rd_o   = run_q & ~held_valid_q & (~stall_i | pending_q);
  assign icache_addr_o = pc_q;
  assign read_done     = icache_rd_o & ~icache_waitrequest_i;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      run_q        <= 1'b0;
      pending_q    <= 1'b0;
      held_valid_q <= 1'b0;
      pc_q         <= pip_isa_pkg::RESET_PC;
      if_inst_o    <= pip_isa_pkg::NOP_WORD;
    end else begin
      run_q     <= 1'b1;
      pending_q <= icache_rd_o & icache_waitrequest_i;
      if (read_done) begin
        pc_q <= pc_q + 32'd4;
      end
      if (!stall_i) begin
        held_valid_q <= 1'b0;
        if (held_valid_q) begin
          if_inst_o <= held_word_q;
        end else if (read_done) begin
          if_inst_o <= icache_data_i;
        end else begin
          if_inst_o <= pip_isa_pkg::NOP_WORD;
        end
      end else if (read_done) begin
        // Word arrived while IF/ID is held
        held_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (read_done && stall_i) begin
      held_word_q <= icache_data_i;
    end
  end

endmodule

/* src/mem.sv */
module mem (
  input  logic                                clock_i,
  input  logic                                reset_i,
  input  logic [pip_ctrl_pkg::DATA_W-1:0]     mem_result_i,
  input  logic [pip_ctrl_pkg::DATA_W-1:0]     mem_store_data_i,
  input  pip_ctrl_pkg::ls_op_t                mem_ls_op_i,
  input  logic [pip_isa_pkg::REG_ADDR_W-1:0]  mem_dest_i,
  input  logic                                mem_dest_valid_i,
  output logic [pip_ctrl_pkg::DATA_W-1:0]     dcache_addr_o,
  output logic                                dcache_rd_o,
  output logic                                dcache_wr_o,
  output logic [pip_ctrl_pkg::DATA_W-1:0]     dcache_wr_data_o,
  output logic [pip_ctrl_pkg::BE_W-1:0]       dcache_wr_be_o,
  input  logic [pip_ctrl_pkg::DATA_W-1:0]     dcache_data_i,
  input  logic                                dcache_waitrequest_i,
  output logic                                stall_o,
  output logic [pip_isa_pkg::REG_ADDR_W-1:0]  rfile_wr_addr1_o,
  output logic                                rfile_wr_enable1_o,
  output logic [pip_ctrl_pkg::DATA_W-1:0]     rfile_wr_data1_o
);

  assign dcache_addr_o    = mem_result_i;
  assign dcache_rd_o      = (mem_ls_op_i == pip_ctrl_pkg::LS_LOAD);
  assign dcache_wr_o      = (mem_ls_op_i == pip_ctrl_pkg::LS_STORE);
  assign dcache_wr_data_o = mem_store_data_i;
  // Word accesses only
  assign dcache_wr_be_o   = '1;

  assign stall_o = (dcache_rd_o | dcache_wr_o) & dcache_waitrequest_i;

  // MEM/WB takes a bubble while the access waits
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      rfile_wr_enable1_o <= 1'b0;
    end else begin
      rfile_wr_enable1_o <= mem_dest_valid_i & ~stall_o;
    end
  end

  always_ff @(posedge clock_i) begin
    rfile_wr_addr1_o <= mem_dest_i;
    rfile_wr_data1_o <= dcache_rd_o ? dcache_data_i : mem_result_i;
  end

endmodule

/* src/pip_ctrl_pkg.sv */
package pip_ctrl_pkg;

  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_LUI
  } alu_op_t;

  // Memory access carried down to the MEM stage
  typedef enum logic [1:0] {
    LS_NONE,
    LS_LOAD,
    LS_STORE
  } ls_op_t;

endpackage

/* src/pip_isa_pkg.sv */
package pip_isa_pkg;

  // Primary opcode field
  typedef enum logic [5:0] {
    OPC_SPECIAL = 6'h00,
    OPC_ADDIU   = 6'h09,
    OPC_SLTI    = 6'h0a,
    OPC_ANDI    = 6'h0c,
    OPC_ORI     = 6'h0d,
    OPC_XORI    = 6'h0e,
    OPC_LUI     = 6'h0f,
    OPC_LW      = 6'h23,
    OPC_SW      = 6'h2b
  } opcode_t;

  // Function field of SPECIAL
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2a,
    FN_SLTU = 6'h2b
  } funct_t;

  // Field positions inside the instruction word
  localparam int OPC_LSB   = 26;
  localparam int RS_LSB    = 21;
  localparam int RT_LSB    = 16;
  localparam int RD_LSB    = 11;
  localparam int SHAMT_LSB = 6;
  localparam int FUNCT_LSB = 0;
  localparam int IMM_W     = 16;

  localparam int REG_ADDR_W = 5;

  localparam logic [31:0] RESET_PC = 32'h0000_0000;
  // SLL r0, r0, 0
  localparam logic [31:0] NOP_WORD = 32'h0000_0000;

endpackage

/* src/pipeline.sv */
module pipeline (
  input  logic                                clock_i,
  input  logic                                reset_i,
  output logic [pip_ctrl_pkg::DATA_W-1:0]     icache_addr_o,
  output logic                                icache_rd_o,
  input  logic [pip_ctrl_pkg::DATA_W-1:0]     icache_data_i,
  input  logic                                icache_waitrequest_i,
  output logic [pip_isa_pkg::REG_ADDR_W-1:0]  rfile_rd_addr1_o,
  output logic [pip_isa_pkg::REG_ADDR_W-1:0]  rfile_rd_addr2_o,
  input  logic [pip_ctrl_pkg::DATA_W-1:0]     rfile_rd_data1_i,
  input  logic [pip_ctrl_pkg::DATA_W-1:0]     rfile_rd_data2_i,
  output logic [pip_ctrl_pkg::DATA_W-1:0]     dcache_addr_o,
  output logic                                dcache_rd_o,
  output logic                                dcache_wr_o,
  output logic [pip_ctrl_pkg::DATA_W-1:0]     dcache_wr_data_o,
  output logic [pip_ctrl_pkg::BE_W-1:0]       dcache_wr_be_o,
  input  logic [pip_ctrl_pkg::DATA_W-1:0]     dcache_data_i,
  input  logic                                dcache_waitrequest_i,
  output logic [pip_isa_pkg::REG_ADDR_W-1:0]  rfile_wr_addr1_o,
  output logic                                rfile_wr_enable1_o,
  output logic [pip_ctrl_pkg::DATA_W-1:0]     rfile_wr_data1_o
);

  logic stall_if;
  logic stall_id;
  logic stall_ex;
  logic mem_stall;
  logic id_stall;

  logic [pip_ctrl_pkg::DATA_W-1:0]     if_inst;
  logic [pip_ctrl_pkg::DATA_W-1:0]     id_a;
  logic [pip_ctrl_pkg::DATA_W-1:0]     id_b;
  logic [pip_ctrl_pkg::DATA_W-1:0]     id_imm;
  logic [pip_isa_pkg::REG_ADDR_W-1:0]  id_rs;
  logic [pip_isa_pkg::REG_ADDR_W-1:0]  id_rt;
  logic [pip_isa_pkg::REG_ADDR_W-1:0]  id_shamt;
  logic [pip_isa_pkg::REG_ADDR_W-1:0]  id_dest;
  logic                                id_dest_valid;
  logic                                id_use_imm;
  pip_ctrl_pkg::alu_op_t               id_alu_op;
  pip_ctrl_pkg::ls_op_t                id_ls_op;

  logic [pip_ctrl_pkg::DATA_W-1:0]     ex_result;
  logic [pip_ctrl_pkg::DATA_W-1:0]     ex_store_data;
  logic [pip_isa_pkg::REG_ADDR_W-1:0]  ex_dest;
  logic                                ex_dest_valid;
  pip_ctrl_pkg::ls_op_t                ex_ls_op;

  // Stall chain
  assign stall_ex = mem_stall;
  assign stall_id = mem_stall;
  assign stall_if = mem_stall | id_stall;

  ifetch u_ifetch (
    .clock_i              (clock_i),
    .reset_i              (reset_i),
    .stall_i              (stall_if),
    .icache_addr_o        (icache_addr_o),
    .icache_rd_o          (icache_rd_o),
    .icache_data_i        (icache_data_i),
    .icache_waitrequest_i (icache_waitrequest_i),
    .if_inst_o            (if_inst)
  );

  idec u_idec (
    .clock_i          (clock_i),
    .reset_i          (reset_i),
    .stall_i          (stall_id),
    .if_inst_i        (if_inst),
    .rfile_rd_addr1_o (rfile_rd_addr1_o),
    .rfile_rd_addr2_o (rfile_rd_addr2_o),
    .rfile_rd_data1_i (rfile_rd_data1_i),
    .rfile_rd_data2_i (rfile_rd_data2_i),
    .hazard_o         (id_stall),
    .ex_a_o           (id_a),
    .ex_b_o           (id_b),
    .ex_rs_o          (id_rs),
    .ex_rt_o          (id_rt),
    .ex_alu_op_o      (id_alu_op),
    .ex_use_imm_o     (id_use_imm),
    .ex_imm_o         (id_imm),
    .ex_shamt_o       (id_shamt),
    .ex_ls_op_o       (id_ls_op),
    .ex_dest_o        (id_dest),
    .ex_dest_valid_o  (id_dest_valid)
  );

  ex u_ex (
    .clock_i          (clock_i),
    .reset_i          (reset_i),
    .stall_i          (stall_ex),
    .ex_a_i           (id_a),
    .ex_b_i           (id_b),
    .ex_rs_i          (id_rs),
    .ex_rt_i          (id_rt),
    .ex_alu_op_i      (id_alu_op),
    .ex_use_imm_i     (id_use_imm),
    .ex_imm_i         (id_imm),
    .ex_shamt_i       (id_shamt),
    .ex_dest_i        (id_dest),
    .ex_dest_valid_i  (id_dest_valid),
    .ls_op_i          (id_ls_op),
    .mem_result_o     (ex_result),
    .mem_store_data_o (ex_store_data),
    .mem_ls_op_o      (ex_ls_op),
    .mem_dest_o       (ex_dest),
    .mem_dest_valid_o (ex_dest_valid),
    .wb_result_i      (rfile_wr_data1_o),
    .wb_dest_i        (rfile_wr_addr1_o),
    .wb_dest_valid_i  (rfile_wr_enable1_o)
  );

  mem u_mem (
    .clock_i              (clock_i),
    .reset_i              (reset_i),
    .mem_result_i         (ex_result),
    .mem_store_data_i     (ex_store_data),
    .mem_ls_op_i          (ex_ls_op),
    .mem_dest_i           (ex_dest),
    .mem_dest_valid_i     (ex_dest_valid),
    .dcache_addr_o        (dcache_addr_o),
    .dcache_rd_o          (dcache_rd_o),
    .dcache_wr_o          (dcache_wr_o),
    .dcache_wr_data_o     (dcache_wr_data_o),
    .dcache_wr_be_o       (dcache_wr_be_o),
    .dcache_data_i        (dcache_data_i),
    .dcache_waitrequest_i (dcache_waitrequest_i),
    .stall_o              (mem_stall),
    .rfile_wr_addr1_o     (rfile_wr_addr1_o),
    .rfile_wr_enable1_o   (rfile_wr_enable1_o),
    .rfile_wr_data1_o     (rfile_wr_data1_o)
  );

endmodule

/* test/pipeline_assertions.sv */
module pipeline_assertions (
  input logic        clock_i,
  input logic        reset_i,
  input logic [31:0] icache_addr_o,
  input logic        icache_rd_o,
  input logic        icache_waitrequest_i,
  input logic [31:0] dcache_addr_o,
  input logic        dcache_rd_o,
  input logic        dcache_wr_o,
  input logic [31:0] dcache_wr_data_o,
  input logic        dcache_waitrequest_i,
  input logic        rfile_wr_enable1_o
);

  timeunit 1ns;
  timeprecision 100ps;

  logic data_quiet;

  assign data_quiet = !dcache_rd_o && !dcache_wr_o && !rfile_wr_enable1_o;

  rd_wr_exclusive: assert property (@(posedge clock_i) disable iff (reset_i)
    !(dcache_rd_o && dcache_wr_o))
    else $error("dcache read and write are high together");

  icache_hold: assert property (@(posedge clock_i) disable iff (reset_i)
    icache_rd_o && icache_waitrequest_i |=> icache_rd_o && $stable(icache_addr_o))
    else $error("icache request changed while waitrequest was high");

  // Address, data and both strobes of a waiting access
  dcache_hold: assert property (@(posedge clock_i) disable iff (reset_i)
    (dcache_rd_o || dcache_wr_o) && dcache_waitrequest_i |=>
      $stable(dcache_rd_o) && $stable(dcache_wr_o) &&
      $stable(dcache_addr_o) && $stable(dcache_wr_data_o))
    else $error("dcache request changed while waitrequest was high");

  fetch_aligned: assert property (@(posedge clock_i) disable iff (reset_i)
    icache_addr_o[1:0] == 2'b00)
    else $error("icache address is not word aligned");

  reset_quiet: assert property (@(posedge clock_i)
    reset_i && $past(reset_i) |-> !icache_rd_o && data_quiet)
    else $error("control output high under reset");

  // First fetch follows reset release by one cycle
  first_fetch: assert property (@(posedge clock_i)
    $fell(reset_i) |-> (!icache_rd_o && data_quiet) ##1 (icache_rd_o && data_quiet))
    else $error("wrong control outputs around the first fetch");

endmodule

/* test/pipeline_tb.sv */
module pipeline_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int PROG_LEN       = 60;
  localparam int IMEM_WORDS     = 128;
  localparam int DMEM_WORDS     = 16;
  localparam int TIMEOUT_CYCLES = 3000;
  localparam int DRAIN_CYCLES   = 40;

  logic        clock_i;
  logic        reset_i;
  logic [31:0] icache_addr_o;
  logic        icache_rd_o;
  logic [31:0] icache_data_i;
  logic        icache_waitrequest_i;
  logic [4:0]  rfile_rd_addr1_o;
  logic [4:0]  rfile_rd_addr2_o;
  logic [31:0] rfile_rd_data1_i;
  logic [31:0] rfile_rd_data2_i;
  logic [31:0] dcache_addr_o;
  logic        dcache_rd_o;
  logic        dcache_wr_o;
  logic [31:0] dcache_wr_data_o;
  logic [3:0]  dcache_wr_be_o;
  logic [31:0] dcache_data_i;
  logic        dcache_waitrequest_i;
  logic [4:0]  rfile_wr_addr1_o;
  logic        rfile_wr_enable1_o;
  logic [31:0] rfile_wr_data1_o;

  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] dmem [DMEM_WORDS];
  logic [31:0] dmem_init [DMEM_WORDS];
  logic [31:0] regs [32];
  logic [31:0] reg_init [32];
  logic [4:0]  recent [3];
  logic [4:0]  exp_wr_addr [$];
  logic [31:0] exp_wr_data [$];
  logic [31:0] exp_st_addr [$];
  logic [31:0] exp_st_data [$];
  int          errors;
  int          wr_seen;
  int          st_seen;
  int          exp_wr_total;
  int          exp_st_total;

  pipeline u_dut (.*);

  bind pipeline pipeline_assertions u_assertions (.*);

  always #2 clock_i = ~clock_i;

  // Memories answer in the same cycle, register file with write-through
  assign icache_data_i = (icache_addr_o < IMEM_WORDS * 4) ? imem[icache_addr_o[8:2]]
                                                          : pip_isa_pkg::NOP_WORD;
  assign dcache_data_i = dmem[dcache_addr_o[5:2]];
  assign rfile_rd_data1_i = (rfile_wr_enable1_o && rfile_wr_addr1_o == rfile_rd_addr1_o)
                            ? rfile_wr_data1_o : regs[rfile_rd_addr1_o];
  assign rfile_rd_data2_i = (rfile_wr_enable1_o && rfile_wr_addr1_o == rfile_rd_addr2_o)
                            ? rfile_wr_data1_o : regs[rfile_rd_addr2_o];

  always @(posedge clock_i) begin
    if (!reset_i && rfile_wr_enable1_o) begin
      regs[rfile_wr_addr1_o] <= rfile_wr_data1_o;
    end
    if (!reset_i && dcache_wr_o && !dcache_waitrequest_i) begin
      dmem[dcache_addr_o[5:2]] <= dcache_wr_data_o;
    end
  end

  // Data cache stays ready for the first half of the program
  always @(posedge clock_i) begin
    icache_waitrequest_i <= ($urandom % 4) == 0;
    dcache_waitrequest_i <= (icache_addr_o >= PROG_LEN * 2) && (($urandom % 3) == 0);
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("[FAIL] %0t ns: %s: got 0x%08h, expected 0x%08h", $time, what, got, expected);
      errors++;
    end
  endtask

  function automatic logic [4:0] pick_source();
    logic [4:0] src;
    case ($urandom % 5)
      0, 1:    src = recent[0];
      2:       src = recent[1];
      3:       src = recent[2];
      default: src = 5'($urandom % 8);
    endcase
    return src;
  endfunction

  function automatic void build_program();
    logic [4:0]           rs;
    logic [4:0]           rt;
    logic [4:0]           dest;
    logic [15:0]          offset;
    pip_isa_pkg::funct_t  fn;
    pip_isa_pkg::opcode_t opc;
    int                   kind;
    recent[0] = 5'd1;
    recent[1] = 5'd2;
    recent[2] = 5'd3;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = pip_isa_pkg::NOP_WORD;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      rs = pick_source();
      rt = pick_source();
      dest = 5'($urandom % 8);
      offset = 16'(($urandom % DMEM_WORDS) * 4);
      kind = $urandom % 10;
      if (kind < 4) begin
        case ($urandom % 9)
          0:       fn = pip_isa_pkg::FN_SLL;
          1:       fn = pip_isa_pkg::FN_SRL;
          2:       fn = pip_isa_pkg::FN_ADDU;
          3:       fn = pip_isa_pkg::FN_SUBU;
          4:       fn = pip_isa_pkg::FN_AND;
          5:       fn = pip_isa_pkg::FN_OR;
          6:       fn = pip_isa_pkg::FN_XOR;
          7:       fn = pip_isa_pkg::FN_SLT;
          default: fn = pip_isa_pkg::FN_SLTU;
        endcase
        imem[i] = {pip_isa_pkg::OPC_SPECIAL, rs, rt, dest, 5'($urandom), fn};
      end else if (kind < 7) begin
        case ($urandom % 6)
          0:       opc = pip_isa_pkg::OPC_ADDIU;
          1:       opc = pip_isa_pkg::OPC_SLTI;
          2:       opc = pip_isa_pkg::OPC_ANDI;
          3:       opc = pip_isa_pkg::OPC_ORI;
          4:       opc = pip_isa_pkg::OPC_XORI;
          default: opc = pip_isa_pkg::OPC_LUI;
        endcase
        imem[i] = {opc, rs, dest, 16'($urandom)};
      end else begin
        // Mostly r0 as base so that loads meet earlier stores
        if ($urandom % 4 != 0) begin
          rs = '0;
        end
        if (kind < 9) begin
          imem[i] = {pip_isa_pkg::OPC_LW, rs, dest, offset};
        end else begin
          imem[i] = {pip_isa_pkg::OPC_SW, rs, rt, offset};
        end
      end
      if (kind < 9) begin
        recent[2] = recent[1];
        recent[1] = recent[0];
        recent[0] = dest;
      end
    end
  endfunction

  // In-order execution of the program on copies of registers and memory
  function automatic void run_reference();
    logic [31:0] regs_m [32];
    logic [31:0] mem_m [DMEM_WORDS];
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_s;
    logic [31:0] imm_z;
    logic [31:0] addr;
    logic [31:0] val;
    logic [4:0]  dest;
    logic        writes;
    regs_m = reg_init;
    mem_m = dmem_init;
    for (int i = 0; i < PROG_LEN; i++) begin
      word = imem[i];
      a = regs_m[word[25:21]];
      b = regs_m[word[20:16]];
      imm_s = {{16{word[15]}}, word[15:0]};
      imm_z = {16'b0, word[15:0]};
      addr = a + imm_s;
      dest = word[20:16];
      writes = 1'b1;
      val = '0;
      case (word[31:26])
        pip_isa_pkg::OPC_SPECIAL: begin
          dest = word[15:11];
          case (word[5:0])
            pip_isa_pkg::FN_SLL:  val = b << word[10:6];
            pip_isa_pkg::FN_SRL:  val = b >> word[10:6];
            pip_isa_pkg::FN_ADDU: val = a + b;
            pip_isa_pkg::FN_SUBU: val = a - b;
            pip_isa_pkg::FN_AND:  val = a & b;
            pip_isa_pkg::FN_OR:   val = a | b;
            pip_isa_pkg::FN_XOR:  val = a ^ b;
            pip_isa_pkg::FN_SLT:  val = {31'b0, $signed(a) < $signed(b)};
            pip_isa_pkg::FN_SLTU: val = {31'b0, a < b};
            default:              writes = 1'b0;
          endcase
        end
        pip_isa_pkg::OPC_ADDIU: val = a + imm_s;
        pip_isa_pkg::OPC_SLTI:  val = {31'b0, $signed(a) < $signed(imm_s)};
        pip_isa_pkg::OPC_ANDI:  val = a & imm_z;
        pip_isa_pkg::OPC_ORI:   val = a | imm_z;
        pip_isa_pkg::OPC_XORI:  val = a ^ imm_z;
        pip_isa_pkg::OPC_LUI:   val = {word[15:0], 16'b0};
        pip_isa_pkg::OPC_LW:    val = mem_m[addr[5:2]];
        pip_isa_pkg::OPC_SW: begin
          exp_st_addr.push_back(addr);
          exp_st_data.push_back(b);
          mem_m[addr[5:2]] = b;
          writes = 1'b0;
        end
        default: writes = 1'b0;
      endcase
      if (writes && dest != 5'd0) begin
        regs_m[dest] = val;
        exp_wr_addr.push_back(dest);
        exp_wr_data.push_back(val);
      end
    end
  endfunction

  always @(posedge clock_i) begin
    if (!reset_i && rfile_wr_enable1_o) begin
      wr_seen++;
      if (exp_wr_addr.size() == 0) begin
        $display("Register write to r%0d at %0t ns with no write left to expect",
                 rfile_wr_addr1_o, $time);
        errors++;
      end else begin
        check_value("register write address", rfile_wr_addr1_o, exp_wr_addr.pop_front());
        check_value("register write data", rfile_wr_data1_o, exp_wr_data.pop_front());
      end
    end
    if (!reset_i && dcache_wr_o && !dcache_waitrequest_i) begin
      st_seen++;
      if (exp_st_addr.size() == 0) begin
        $display("Store to 0x%08h at %0t ns with no store left to expect",
                 dcache_addr_o, $time);
        errors++;
      end else begin
        check_value("store address", dcache_addr_o, exp_st_addr.pop_front());
        check_value("store data", dcache_wr_data_o, exp_st_data.pop_front());
        check_value("store byte enables", dcache_wr_be_o, 32'hf);
      end
    end
  end

  initial begin
    int unsigned seed;
    int          cycles;
    seed = 32'hf500;
    void'($urandom(seed));
    clock_i = 1'b0;
    reset_i = 1'b1;
    icache_waitrequest_i = 1'b0;
    dcache_waitrequest_i = 1'b0;
    errors = 0;
    wr_seen = 0;
    st_seen = 0;
    for (int i = 0; i < 32; i++) begin
      reg_init[i] = (i == 0) ? 32'd0 : $urandom;
      regs[i] = reg_init[i];
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem_init[i] = $urandom;
      dmem[i] = dmem_init[i];
    end
    build_program();
    run_reference();
    exp_wr_total = exp_wr_addr.size();
    exp_st_total = exp_st_addr.size();
    repeat (2) @(posedge clock_i);
    reset_i <= 1'b0;
    cycles = 0;
    while ((wr_seen < exp_wr_total || st_seen < exp_st_total) && cycles < TIMEOUT_CYCLES) begin
      @(posedge clock_i);
      cycles++;
    end
    if (wr_seen < exp_wr_total || st_seen < exp_st_total) begin
      $display("Timed out waiting for the expected register writes and stores");
      errors++;
    end
    // Let late duplicates show up
    cycles = 0;
    while (cycles < DRAIN_CYCLES) begin
      @(posedge clock_i);
      cycles++;
    end
    check_value("register write count", wr_seen, exp_wr_total);
    check_value("store count", st_seen, exp_st_total);
    $display("Errors: %0d, register writes %0d of %0d, stores %0d of %0d",
             errors, wr_seen, exp_wr_total, st_seen, exp_st_total);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
